//--- vlog.f
+incdir+logic
logic/lsu_pkg.sv
logic/spill_cell_flush.sv
logic/ls_req_queue.sv
logic/address_adder.sv
logic/mem_access_unit.sv
logic/lsu_agu_top.sv
dv/tb_lsu_agu.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_lsu_agu
RTL_TOP   ?= lsu_agu_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_lsu_agu.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module tb_lsu_agu;

  localparam int N_BP       = 40;
  localparam int N_LAT      = 20;
  // Aligned 32, misaligned 14, flush 12, plus the random runs
  localparam int TOTAL_REQS = 32 + 14 + N_BP + N_LAT + 12;
  localparam int BP_OPEN    = 0;
  localparam int BP_RANDOM  = 1;
  localparam int BP_HOLD    = 2;
  // One held request in each registered spill cell
  localparam int PIPE_REGS  = `LSU_SPILL_SKIP ? 0 : 2;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  flush_i;
  logic                  issue_valid_i;
  logic                  issue_ready_o;
  logic [`LSU_TAG_W-1:0] issue_tag_i;
  logic [`LSU_XLEN-1:0]  issue_base_i;
  logic [`LSU_XLEN-1:0]  issue_offs_i;
  lsu_pkg::ls_type_e     issue_ls_type_i;
  logic                  issue_is_store_i;
  logic [`LSU_XLEN-1:0]  issue_data_i;
  logic                  cpl_valid_o;
  logic                  cpl_ready_i;
  logic [`LSU_TAG_W-1:0] cpl_tag_o;
  logic [`LSU_XLEN-1:0]  cpl_data_o;
  logic                  cpl_except_o;
  lsu_pkg::except_code_e cpl_except_code_o;

  // ------------------------------------------------------------
  // Reference model state
  // ------------------------------------------------------------
  logic [7:0]            shadow [`LSU_MEM_WORDS*8];
  logic [`LSU_TAG_W-1:0] pend_tag  [$];
  logic [`LSU_XLEN-1:0]  pend_addr [$];
  lsu_pkg::ls_type_e     pend_type [$];
  logic                  pend_st   [$];
  logic [`LSU_XLEN-1:0]  pend_data [$];
  int                    pend_cyc  [$];

  int                    seed = 44;
  int                    cyc;
  int                    outstanding;
  int                    bp_mode;
  bit                    lat_on;
  int                    err_count;
  int                    err_at_start;
  int                    pass_tests;
  int                    fail_tests;
  string                 cur_test;
  logic [`LSU_TAG_W-1:0] next_tag;

  lsu_agu_top i_dut (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .flush_i           (flush_i),
    .issue_valid_i     (issue_valid_i),
    .issue_ready_o     (issue_ready_o),
    .issue_tag_i       (issue_tag_i),
    .issue_base_i      (issue_base_i),
    .issue_offs_i      (issue_offs_i),
    .issue_ls_type_i   (issue_ls_type_i),
    .issue_is_store_i  (issue_is_store_i),
    .issue_data_i      (issue_data_i),
    .cpl_valid_o       (cpl_valid_o),
    .cpl_ready_i       (cpl_ready_i),
    .cpl_tag_o         (cpl_tag_o),
    .cpl_data_o        (cpl_data_o),
    .cpl_except_o      (cpl_except_o),
    .cpl_except_code_o (cpl_except_code_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Bytes moved by one access
  function automatic int size_of(input lsu_pkg::ls_type_e t);
    case (t)
      lsu_pkg::LS_BYTE, lsu_pkg::LS_BYTE_U:         return 1;
      lsu_pkg::LS_HALFWORD, lsu_pkg::LS_HALFWORD_U: return 2;
      lsu_pkg::LS_WORD, lsu_pkg::LS_WORD_U:         return 4;
      default:                                      return 8;
    endcase
  endfunction

  function automatic bit sign_extends(input lsu_pkg::ls_type_e t);
    return (t == lsu_pkg::LS_BYTE) || (t == lsu_pkg::LS_HALFWORD) || (t == lsu_pkg::LS_WORD);
  endfunction

  function automatic logic [`LSU_XLEN-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic report_mismatch(input string field, input logic [63:0] exp,
                                 input logic [63:0] act);
    err_count++;
    $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, field, exp, act);
  endtask

  task automatic begin_test(input string name);
    cur_test     = name;
    err_at_start = err_count;
  endtask

  task automatic end_test();
    if (err_count == err_at_start) begin
      pass_tests++;
      $display("test %s: ok", cur_test);
    end else begin
      fail_tests++;
      $display("test %s: %0d errors", cur_test, err_count - err_at_start);
    end
  endtask

  // ------------------------------------------------------------
  // Completion checker, model applied in issue order
  // ------------------------------------------------------------
  task automatic check_completion();
    logic [`LSU_TAG_W-1:0] exp_tag;
    logic [`LSU_XLEN-1:0]  addr;
    logic [`LSU_XLEN-1:0]  data;
    logic [`LSU_XLEN-1:0]  exp_data;
    lsu_pkg::ls_type_e     t;
    logic                  st;
    logic                  exp_exc;
    logic [3:0]            exp_code;
    int                    n;
    int                    b;
    int                    c;
    if (pend_tag.size() == 0) begin
      err_count++;
      $display("%s: completion with tag %0d arrived with nothing outstanding",
               cur_test, cpl_tag_o);
      return;
    end
    exp_tag  = pend_tag.pop_front();
    addr     = pend_addr.pop_front();
    t        = pend_type.pop_front();
    st       = pend_st.pop_front();
    data     = pend_data.pop_front();
    c        = pend_cyc.pop_front();
    n        = size_of(t);
    b        = int'(addr % (`LSU_MEM_WORDS * 8));
    exp_data = '0;
    exp_exc  = (addr & 64'(n - 1)) != 0;
    exp_code = st ? 4'd6 : 4'd4;
    if (!exp_exc && st) begin
      for (int i = 0; i < n; i++) begin
        shadow[b + i] = data[8*i +: 8];
      end
    end else if (!exp_exc) begin
      for (int i = 0; i < n; i++) begin
        exp_data[8*i +: 8] = shadow[b + i];
      end
      // Fill the upper bits with the top loaded bit
      if (sign_extends(t) && exp_data[8*n-1]) begin
        for (int i = 8 * n; i < `LSU_XLEN; i++) begin
          exp_data[i] = 1'b1;
        end
      end
    end
    assert (cpl_tag_o == exp_tag)
      else report_mismatch("tag", 64'(exp_tag), 64'(cpl_tag_o));
    assert (cpl_data_o == exp_data)
      else report_mismatch("data", exp_data, cpl_data_o);
    assert (cpl_except_o == exp_exc)
      else report_mismatch("except", 64'(exp_exc), 64'(cpl_except_o));
    if (exp_exc) begin
      assert (4'(cpl_except_code_o) == exp_code)
        else report_mismatch("code", 64'(exp_code), 64'(cpl_except_code_o));
    end
    if (lat_on) begin
      assert (cyc - c == 3)
        else report_mismatch("latency", 64'd3, 64'(cyc - c));
    end
  endtask

  // Pending requests in order, cleared by flush
  always @(posedge clk_i) begin
    cyc++;
    if (rst_n_i) begin
      if (cpl_valid_o && cpl_ready_i) begin
        check_completion();
      end
      // A push in the flush cycle is dropped by the queue
      if (issue_valid_i && issue_ready_o && !flush_i) begin
        pend_tag.push_back(issue_tag_i);
        pend_addr.push_back(issue_base_i + issue_offs_i);
        pend_type.push_back(issue_ls_type_i);
        pend_st.push_back(issue_is_store_i);
        pend_data.push_back(issue_data_i);
        pend_cyc.push_back(cyc);
      end
      if (flush_i) begin
        pend_tag.delete();
        pend_addr.delete();
        pend_type.delete();
        pend_st.delete();
        pend_data.delete();
        pend_cyc.delete();
      end
      outstanding = pend_tag.size();
    end
  end

  // Completion back-pressure
  always @(posedge clk_i) begin
    case (bp_mode)
      BP_RANDOM: cpl_ready_i <= ($random(seed) & 1) != 0;
      BP_HOLD:   cpl_ready_i <= 1'b0;
      default:   cpl_ready_i <= 1'b1;
    endcase
  end

  // ------------------------------------------------------------
  // Protocol assertions
  // ------------------------------------------------------------
  a_cpl_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cpl_valid_o && !cpl_ready_i && !flush_i) |=>
      (cpl_valid_o && $stable(cpl_tag_o) && $stable(cpl_data_o) &&
       $stable(cpl_except_o) && $stable(cpl_except_code_o)))
    else begin
      err_count++;
      $display("%s: completion changed or dropped while stalled", cur_test);
    end

  // Full queue sits behind a stalled pipe, so every stage holds a request
  a_ready_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !issue_ready_o |-> (outstanding >= `LSU_REQ_DEPTH + PIPE_REGS))
    else begin
      err_count++;
      $display("%s: issue_ready_o low with %0d requests in flight", cur_test, outstanding);
    end

  task automatic send_request(input logic [`LSU_XLEN-1:0] addr, input lsu_pkg::ls_type_e t,
                              input logic st, input logic [`LSU_XLEN-1:0] data);
    logic [`LSU_XLEN-1:0] base;
    base = rand64();
    issue_valid_i    <= 1'b1;
    issue_tag_i      <= next_tag;
    issue_base_i     <= base;
    issue_offs_i     <= addr - base;
    issue_ls_type_i  <= t;
    issue_is_store_i <= st;
    issue_data_i     <= data;
    @(posedge clk_i);
    while (!issue_ready_o) begin
      @(posedge clk_i);
    end
    issue_valid_i <= 1'b0;
    next_tag = next_tag + 1'b1;
  endtask

  // Model queues are settled between clock edges
  task automatic wait_drained();
    @(negedge clk_i);
    while (pend_tag.size() != 0) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
  endtask

  initial begin : watchdog
    repeat (TOTAL_REQS * 40 + 200) @(posedge clk_i);
    $display("watchdog expired in %s, the DUT stopped completing requests", cur_test);
    $display("sim failed");
    $finish;
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin : stimulus
    lsu_pkg::ls_type_e    t;
    logic [`LSU_XLEN-1:0] addr;
    logic [`LSU_XLEN-1:0] faddr;
    int                   off;
    rst_n_i          = 1'b0;
    flush_i          = 1'b0;
    issue_valid_i    = 1'b0;
    issue_tag_i      = '0;
    issue_base_i     = '0;
    issue_offs_i     = '0;
    issue_ls_type_i  = lsu_pkg::LS_BYTE;
    issue_is_store_i = 1'b0;
    issue_data_i     = '0;
    cpl_ready_i      = 1'b1;
    bp_mode          = BP_OPEN;
    lat_on           = 1'b0;
    next_tag         = '0;
    for (int i = 0; i < `LSU_MEM_WORDS * 8; i++) begin
      shadow[i] = 8'h00;
    end
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    begin_test("reset");
    assert (!cpl_valid_o) else report_mismatch("cpl_valid_o", 64'd0, 64'(cpl_valid_o));
    assert (issue_ready_o) else report_mismatch("issue_ready_o", 64'd1, 64'(issue_ready_o));
    end_test();

    // One store per width in its own doubleword, then every load width
    begin_test("aligned");
    for (int w = 0; w < 4; w++) begin
      off  = ($random(seed) & 7) & ~((1 << w) - 1);
      addr = (rand64() & ~64'h7f) | 64'(8 * w + off);
      send_request(addr, lsu_pkg::ls_type_e'(3'(2 * w)), 1'b1, rand64());
    end
    for (int w = 0; w < 4; w++) begin
      for (int k = 0; k < 7; k++) begin
        t    = lsu_pkg::ls_type_e'(3'(k));
        addr = (rand64() & ~64'h7f) | 64'(8 * w + ($random(seed) & 7));
        send_request(addr & ~64'(size_of(t) - 1), t, 1'b0, '0);
      end
    end
    wait_drained();
    end_test();

    // Odd offsets are misaligned for every width above a byte
    begin_test("misaligned");
    send_request(64'h20, lsu_pkg::LS_DOUBLEWORD, 1'b1, rand64());
    for (int i = 0; i < 6; i++) begin
      t    = lsu_pkg::ls_type_e'(3'(2 + i % 5));
      addr = 64'h20 + 64'((2 * i) % 8 + 1);
      send_request(addr, t, 1'b1, rand64());
      send_request(addr, t, 1'b0, '0);
    end
    send_request(64'h20, lsu_pkg::LS_DOUBLEWORD, 1'b0, '0);
    wait_drained();
    end_test();

    begin_test("backpressure");
    bp_mode <= BP_RANDOM;
    for (int i = 0; i < N_BP; i++) begin
      t    = lsu_pkg::ls_type_e'(3'($unsigned($random(seed)) % 7));
      addr = rand64();
      if (($random(seed) & 3) != 0) begin
        addr = addr & ~64'(size_of(t) - 1);
      end
      send_request(addr, t, ($random(seed) & 1) != 0, rand64());
    end
    wait_drained();
    end_test();

    begin_test("latency");
    bp_mode <= BP_OPEN;
    repeat (2) @(posedge clk_i);
    lat_on <= 1'b1;
    for (int i = 0; i < N_LAT; i++) begin
      t = lsu_pkg::ls_type_e'(3'($unsigned($random(seed)) % 7));
      send_request(rand64() & ~64'(size_of(t) - 1), t, ($random(seed) & 1) != 0, rand64());
    end
    wait_drained();
    lat_on <= 1'b0;
    end_test();

    // Loads stall the pipe so the stores stay behind them
    begin_test("flush");
    faddr = 64'h40;
    send_request(faddr, lsu_pkg::LS_DOUBLEWORD, 1'b1, '0);
    send_request(faddr + 8, lsu_pkg::LS_DOUBLEWORD, 1'b1, '0);
    wait_drained();
    bp_mode <= BP_HOLD;
    repeat (2) @(posedge clk_i);
    send_request(faddr, lsu_pkg::LS_DOUBLEWORD, 1'b0, '0);
    send_request(faddr, lsu_pkg::LS_WORD, 1'b0, '0);
    send_request(faddr, lsu_pkg::LS_DOUBLEWORD, 1'b1, 64'hdead_beef_cafe_f00d);
    send_request(faddr + 8, lsu_pkg::LS_WORD, 1'b1, 64'h1234_5678_9abc_def0);
    send_request(faddr + 3, lsu_pkg::LS_BYTE, 1'b1, 64'h5a);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    bp_mode <= BP_OPEN;
    @(posedge clk_i);
    assert (!cpl_valid_o) else begin
      err_count++;
      $display("%s: completion still valid after the flush", cur_test);
    end
    // Store reaches the access unit on the flush edge, two cycles after issue
    send_request(faddr, lsu_pkg::LS_DOUBLEWORD, 1'b1, 64'h0bad_0bad_0bad_0bad);
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    send_request(faddr, lsu_pkg::LS_DOUBLEWORD, 1'b0, '0);
    send_request(faddr + 8, lsu_pkg::LS_WORD_U, 1'b0, '0);
    send_request(faddr + 3, lsu_pkg::LS_BYTE, 1'b1, 64'h81);
    send_request(faddr + 3, lsu_pkg::LS_BYTE, 1'b0, '0);
    wait_drained();
    end_test();

    $display("tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_count);
    if (fail_tests == 0 && err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- logic/lsu_agu_top.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_agu_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,

  // Issue side
  input  logic                   issue_valid_i,
  output logic                   issue_ready_o,
  input  logic [`LSU_TAG_W-1:0]  issue_tag_i,
  input  logic [`LSU_XLEN-1:0]   issue_base_i,
  input  logic [`LSU_XLEN-1:0]   issue_offs_i,
  input  lsu_pkg::ls_type_e      issue_ls_type_i,
  input  logic                   issue_is_store_i,
  input  logic [`LSU_XLEN-1:0]   issue_data_i,

  // Completion side
  output logic                   cpl_valid_o,
  input  logic                   cpl_ready_i,
  output logic [`LSU_TAG_W-1:0]  cpl_tag_o,
  output logic [`LSU_XLEN-1:0]   cpl_data_o,
  output logic                   cpl_except_o,
  output lsu_pkg::except_code_e  cpl_except_code_o
);

  // ------------------------------------------------------------
  // Queue to adder
  // ------------------------------------------------------------
  logic                  q_valid;
  logic                  q_ready;
  logic [`LSU_TAG_W-1:0] q_tag;
  logic [`LSU_XLEN-1:0]  q_base;
  logic [`LSU_XLEN-1:0]  q_offs;
  lsu_pkg::ls_type_e     q_ls_type;
  logic                  q_is_store;
  logic [`LSU_XLEN-1:0]  q_data;

  // Adder to access unit
  logic                  a_valid;
  logic                  a_ready;
  logic [`LSU_TAG_W-1:0] a_tag;
  logic [`LSU_XLEN-1:0]  a_addr;
  logic [`LSU_XLEN-1:0]  a_st_data;
  lsu_pkg::ls_type_e     a_ls_type;
  logic                  a_is_store;
  logic                  a_except;
  lsu_pkg::except_code_e a_except_code;

  ls_req_queue #(
    .DEPTH (`LSU_REQ_DEPTH)
  ) i_req_queue (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .in_valid_i     (issue_valid_i),
    .in_ready_o     (issue_ready_o),
    .in_tag_i       (issue_tag_i),
    .in_base_i      (issue_base_i),
    .in_offs_i      (issue_offs_i),
    .in_ls_type_i   (issue_ls_type_i),
    .in_is_store_i  (issue_is_store_i),
    .in_data_i      (issue_data_i),
    .out_valid_o    (q_valid),
    .out_ready_i    (q_ready),
    .out_tag_o      (q_tag),
    .out_base_o     (q_base),
    .out_offs_o     (q_offs),
    .out_ls_type_o  (q_ls_type),
    .out_is_store_o (q_is_store),
    .out_data_o     (q_data)
  );

  // Effective address and alignment fault
  address_adder i_addr_adder (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .valid_i       (q_valid),
    .ready_i       (a_ready),
    .valid_o       (a_valid),
    .ready_o       (q_ready),
    .tag_i         (q_tag),
    .base_i        (q_base),
    .offs_i        (q_offs),
    .ls_type_i     (q_ls_type),
    .is_store_i    (q_is_store),
    .st_data_i     (q_data),
    .tag_o         (a_tag),
    .addr_o        (a_addr),
    .st_data_o     (a_st_data),
    .ls_type_o     (a_ls_type),
    .is_store_o    (a_is_store),
    .except_o      (a_except),
    .except_code_o (a_except_code)
  );

  // Memory access and in-order completion
  mem_access_unit i_mem_access (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .flush_i           (flush_i),
    .valid_i           (a_valid),
    .ready_o           (a_ready),
    .tag_i             (a_tag),
    .addr_i            (a_addr),
    .st_data_i         (a_st_data),
    .ls_type_i         (a_ls_type),
    .is_store_i        (a_is_store),
    .except_i          (a_except),
    .except_code_i     (a_except_code),
    .cpl_valid_o       (cpl_valid_o),
    .cpl_ready_i       (cpl_ready_i),
    .cpl_tag_o         (cpl_tag_o),
    .cpl_data_o        (cpl_data_o),
    .cpl_except_o      (cpl_except_o),
    .cpl_except_code_o (cpl_except_code_o)
  );

endmodule

//--- logic/mem_access_unit.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module mem_access_unit (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,

  // From the address adder
  input  logic                   valid_i,
  output logic                   ready_o,
  input  logic [`LSU_TAG_W-1:0]  tag_i,
  input  logic [`LSU_XLEN-1:0]   addr_i,
  input  logic [`LSU_XLEN-1:0]   st_data_i,
  input  lsu_pkg::ls_type_e      ls_type_i,
  input  logic                   is_store_i,
  input  logic                   except_i,
  input  lsu_pkg::except_code_e  except_code_i,

  // Completion port
  output logic                   cpl_valid_o,
  input  logic                   cpl_ready_i,
  output logic [`LSU_TAG_W-1:0]  cpl_tag_o,
  output logic [`LSU_XLEN-1:0]   cpl_data_o,
  output logic                   cpl_except_o,
  output lsu_pkg::except_code_e  cpl_except_code_o
);

  localparam int NBYTES = `LSU_XLEN / 8;
  localparam int OFF_W  = $clog2(NBYTES);
  localparam int IDX_W  = $clog2(`LSU_MEM_WORDS);

  // ------------------------------------------------------------
  // Local data memory
  // ------------------------------------------------------------
  logic [`LSU_XLEN-1:0] mem_q [`LSU_MEM_WORDS];

  logic [IDX_W-1:0]     idx;
  logic [OFF_W-1:0]     off;
  logic [NBYTES-1:0]    size_mask;
  logic [NBYTES-1:0]    byte_en;
  logic [`LSU_XLEN-1:0] wr_data;
  logic [`LSU_XLEN-1:0] rd_shift;
  logic [`LSU_XLEN-1:0] ld_data;
  logic                 accept;
  logic                 mem_we;
  lsu_pkg::lsu_cpl_t    cpl_d;
  lsu_pkg::lsu_cpl_t    cpl_q;

  // Doubleword index above the byte offset, upper bits ignored
  assign idx = addr_i[IDX_W+OFF_W-1:OFF_W];
  assign off = addr_i[OFF_W-1:0];

  assign accept = valid_i & ready_o;
  // No write for faults or in a flush cycle
  assign mem_we = accept & is_store_i & ~except_i & ~flush_i;

  // Bytes touched by the access, before the offset shift
  always_comb begin
    case (ls_type_i)
      lsu_pkg::LS_BYTE, lsu_pkg::LS_BYTE_U:         size_mask = NBYTES'(8'h01);
      lsu_pkg::LS_HALFWORD, lsu_pkg::LS_HALFWORD_U: size_mask = NBYTES'(8'h03);
      lsu_pkg::LS_WORD, lsu_pkg::LS_WORD_U:         size_mask = NBYTES'(8'h0f);
      lsu_pkg::LS_DOUBLEWORD:                       size_mask = NBYTES'(8'hff);
      default:                                      size_mask = '0;
    endcase
  end

  assign byte_en = size_mask << off;
  // Low bytes of the store data moved to their lanes
  assign wr_data = st_data_i << {off, 3'b000};

  // Cleared on reset, then byte-lane writes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int w = 0; w < `LSU_MEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (mem_we) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (byte_en[b]) begin
          mem_q[idx][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Load extraction and extension
  // ------------------------------------------------------------
  // Addressed byte lands in bits 7:0
  assign rd_shift = mem_q[idx] >> {off, 3'b000};

  always_comb begin
    case (ls_type_i)
      lsu_pkg::LS_BYTE:       ld_data = {{(`LSU_XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
      lsu_pkg::LS_BYTE_U:     ld_data = {{(`LSU_XLEN-8){1'b0}}, rd_shift[7:0]};
      lsu_pkg::LS_HALFWORD:   ld_data = {{(`LSU_XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
      lsu_pkg::LS_HALFWORD_U: ld_data = {{(`LSU_XLEN-16){1'b0}}, rd_shift[15:0]};
      lsu_pkg::LS_WORD:       ld_data = {{(`LSU_XLEN-32){rd_shift[31]}}, rd_shift[31:0]};
      lsu_pkg::LS_WORD_U:     ld_data = {{(`LSU_XLEN-32){1'b0}}, rd_shift[31:0]};
      default:                ld_data = rd_shift;
    endcase
  end

  // Stores and faults return zero data
  always_comb begin
    cpl_d.tag           = tag_i;
    cpl_d.data          = (except_i || is_store_i) ? '0 : ld_data;
    cpl_d.except_raised = except_i;
    cpl_d.except_code   = except_code_i;
  end

  // Completion stage, sampled at acceptance
  spill_cell_flush #(
    .DATA_T (lsu_pkg::lsu_cpl_t),
    .SKIP   (`LSU_SPILL_SKIP)
  ) i_cpl_cell (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_i  (cpl_d),
    .valid_o (cpl_valid_o),
    .ready_i (cpl_ready_i),
    .data_o  (cpl_q)
  );

  assign cpl_tag_o         = cpl_q.tag;
  assign cpl_data_o        = cpl_q.data;
  assign cpl_except_o      = cpl_q.except_raised;
  assign cpl_except_code_o = cpl_q.except_code;

endmodule

//--- logic/address_adder.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module address_adder (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,

  // Handshake
  input  logic                   valid_i,
  input  logic                   ready_i,
  output logic                   valid_o,
  output logic                   ready_o,

  // Request from the queue
  input  logic [`LSU_TAG_W-1:0]  tag_i,
  input  logic [`LSU_XLEN-1:0]   base_i,
  input  logic [`LSU_XLEN-1:0]   offs_i,
  input  lsu_pkg::ls_type_e      ls_type_i,
  input  logic                   is_store_i,
  input  logic [`LSU_XLEN-1:0]   st_data_i,

  // Answer to the access unit
  output logic [`LSU_TAG_W-1:0]  tag_o,
  output logic [`LSU_XLEN-1:0]   addr_o,
  output logic [`LSU_XLEN-1:0]   st_data_o,
  output lsu_pkg::ls_type_e      ls_type_o,
  output logic                   is_store_o,
  output logic                   except_o,
  output lsu_pkg::except_code_e  except_code_o
);

  logic [`LSU_XLEN-1:0] eff_addr;
  logic                 misaligned;
  lsu_pkg::adder_ans_t  ans_d;
  lsu_pkg::adder_ans_t  ans_q;

  // Wraps modulo 2^XLEN
  assign eff_addr = base_i + offs_i;

  // ------------------------------------------------------------
  // Natural alignment check
  // ------------------------------------------------------------
  always_comb begin
    case (ls_type_i)
      lsu_pkg::LS_HALFWORD, lsu_pkg::LS_HALFWORD_U: misaligned = eff_addr[0];
      lsu_pkg::LS_WORD, lsu_pkg::LS_WORD_U:         misaligned = |eff_addr[1:0];
      lsu_pkg::LS_DOUBLEWORD:                       misaligned = |eff_addr[2:0];
      // Bytes are always aligned
      default:                                      misaligned = 1'b0;
    endcase
  end

  // Pack the answer
  always_comb begin
    ans_d.tag           = tag_i;
    ans_d.addr          = eff_addr;
    ans_d.st_data       = st_data_i;
    ans_d.ls_type       = ls_type_i;
    ans_d.is_store      = is_store_i;
    ans_d.except_raised = misaligned;
    ans_d.except_code   = is_store_i ? lsu_pkg::E_ST_ADDR_MISALIGNED
                                     : lsu_pkg::E_LD_ADDR_MISALIGNED;
  end

  // Output stage, one cycle
  spill_cell_flush #(
    .DATA_T (lsu_pkg::adder_ans_t),
    .SKIP   (`LSU_SPILL_SKIP)
  ) i_ans_cell (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_i  (ans_d),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (ans_q)
  );

  // Unpack to loose ports
  assign tag_o         = ans_q.tag;
  assign addr_o        = ans_q.addr;
  assign st_data_o     = ans_q.st_data;
  assign ls_type_o     = ans_q.ls_type;
  assign is_store_o    = ans_q.is_store;
  assign except_o      = ans_q.except_raised;
  assign except_code_o = ans_q.except_code;

endmodule

//--- logic/ls_req_queue.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module ls_req_queue #(
  parameter int DEPTH = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,

  // Issue side
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic [`LSU_TAG_W-1:0] in_tag_i,
  input  logic [`LSU_XLEN-1:0]  in_base_i,
  input  logic [`LSU_XLEN-1:0]  in_offs_i,
  input  lsu_pkg::ls_type_e     in_ls_type_i,
  input  logic                  in_is_store_i,
  input  logic [`LSU_XLEN-1:0]  in_data_i,

  // Address adder side
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [`LSU_TAG_W-1:0] out_tag_o,
  output logic [`LSU_XLEN-1:0]  out_base_o,
  output logic [`LSU_XLEN-1:0]  out_offs_o,
  output lsu_pkg::ls_type_e     out_ls_type_o,
  output logic                  out_is_store_o,
  output logic [`LSU_XLEN-1:0]  out_data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // ------------------------------------------------------------
  // Storage, one array per request field
  // ------------------------------------------------------------
  logic [`LSU_TAG_W-1:0] tag_mem   [DEPTH];
  logic [`LSU_XLEN-1:0]  base_mem  [DEPTH];
  logic [`LSU_XLEN-1:0]  offs_mem  [DEPTH];
  lsu_pkg::ls_type_e     type_mem  [DEPTH];
  logic                  store_mem [DEPTH];
  logic [`LSU_XLEN-1:0]  data_mem  [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push;
  logic             pop;

  // Full only blocks the issue side
  assign in_ready_o  = (cnt_q != CNT_W'(DEPTH));
  assign out_valid_o = (cnt_q != '0);

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // Write the entry at the tail
  always_ff @(posedge clk_i) begin
    if (push) begin
      tag_mem[wr_ptr_q]   <= in_tag_i;
      base_mem[wr_ptr_q]  <= in_base_i;
      offs_mem[wr_ptr_q]  <= in_offs_i;
      type_mem[wr_ptr_q]  <= in_ls_type_i;
      store_mem[wr_ptr_q] <= in_is_store_i;
      data_mem[wr_ptr_q]  <= in_data_i;
    end
  end

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------
  // Flush wins over a push in the same cycle, that request is dropped
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Head entry
  assign out_tag_o      = tag_mem[rd_ptr_q];
  assign out_base_o     = base_mem[rd_ptr_q];
  assign out_offs_o     = offs_mem[rd_ptr_q];
  assign out_ls_type_o  = type_mem[rd_ptr_q];
  assign out_is_store_o = store_mem[rd_ptr_q];
  assign out_data_o     = data_mem[rd_ptr_q];

endmodule

//--- logic/spill_cell_flush.sv
`timescale 1ns/1ps

module spill_cell_flush #(
  parameter type DATA_T = logic,
  parameter bit  SKIP   = 1'b0
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  flush_i,

  // Upstream side
  input  logic  valid_i,
  output logic  ready_o,
  input  DATA_T data_i,

  // Downstream side
  output logic  valid_o,
  input  logic  ready_i,
  output DATA_T data_o
);

  generate
    if (SKIP) begin : gen_skip
      // Plain wires, zero cycles of latency
      assign valid_o = valid_i;
      assign ready_o = ready_i;
      assign data_o  = data_i;
    end else begin : gen_reg
      logic  valid_q;
      DATA_T data_q;

      // Free slot, or the held entry leaves this cycle
      assign ready_o = ~valid_q | ready_i;

      // Valid bit, cleared by reset and by flush
      always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
          valid_q <= 1'b0;
        end else if (ready_o) begin
          valid_q <= valid_i;
        end
      end

      // Payload only moves on a transfer
      always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
          data_q <= data_i;
        end
      end

      assign valid_o = valid_q;
      assign data_o  = data_q;
    end
  endgenerate

endmodule

//--- logic/lsu_pkg.sv
`include "lsu_config.svh"

package lsu_pkg;

  // ------------------------------------------------------------
  // Access width encoding
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    LS_BYTE       = 3'd0,
    LS_BYTE_U     = 3'd1,
    LS_HALFWORD   = 3'd2,
    LS_HALFWORD_U = 3'd3,
    LS_WORD       = 3'd4,
    LS_WORD_U     = 3'd5,
    LS_DOUBLEWORD = 3'd6
  } ls_type_e;

  // Exception causes raised by the address path
  typedef enum logic [3:0] {
    E_LD_ADDR_MISALIGNED = 4'd4,
    E_ST_ADDR_MISALIGNED = 4'd6
  } except_code_e;

  // ------------------------------------------------------------
  // Buffered payloads
  // ------------------------------------------------------------

  // Address adder answer, one per request
  typedef struct packed {
    logic [`LSU_TAG_W-1:0] tag;
    logic [`LSU_XLEN-1:0]  addr;
    logic [`LSU_XLEN-1:0]  st_data;
    ls_type_e              ls_type;
    logic                  is_store;
    logic                  except_raised;
    except_code_e          except_code;
  } adder_ans_t;

  // Completion returned to issue
  typedef struct packed {
    logic [`LSU_TAG_W-1:0] tag;
    logic [`LSU_XLEN-1:0]  data;
    logic                  except_raised;
    except_code_e          except_code;
  } lsu_cpl_t;

endpackage

//--- logic/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// ------------------------------------------------------------
// Load/store unit configuration
// ------------------------------------------------------------

// Data and address width
`define LSU_XLEN 64

// Request tag width
`define LSU_TAG_W 4

// Entries in the issue request queue
`define LSU_REQ_DEPTH 4

// Doublewords of local data memory
`define LSU_MEM_WORDS 16

// Spill cells: 0 registered, 1 pass-through
`define LSU_SPILL_SKIP 1'b0

`endif
